/* hw/ddr_ctrl_defines.svh */
`ifndef DDR_CTRL_DEFINES_SVH
`define DDR_CTRL_DEFINES_SVH

// request address split into row, bank and column
`define DDR_ROW_MSB 26
`define DDR_ROW_LSB 15
`define DDR_BANK_MSB 14
`define DDR_BANK_LSB 13
`define DDR_COL_MSB 12

// spacing counter, a new command may go once it reads DDR_CNT_DONE
`define DDR_CNT_DONE 4'd15
`define DDR_CNT_ACTV 4'd12      // 3 cycles to done
`define DDR_CNT_ARSR 4'd0       // refresh cycle time
`define DDR_CNT_DEFAULT 4'd11   // PRCH, READ, WRTE

// precharge all banks, A10 high
`define DDR_PRCH_ADDR 13'h0400

// READ on the bus to first read beat on dq_in
`define DDR_CAS_LAT 3

`endif

/* hw/ddr_ctrl_pkg.sv */
`default_nettype none

package ddr_ctrl_pkg;

  // encoded as the {ras_n, cas_n, we_n} pins of the device
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } ddr_cmd_e;

  // client request
  typedef struct packed {
    logic [26:0] addr;    // row, bank, column
    logic        we;
    logic [31:0] wdata;
  } mem_req_t;

  // one word on the command bus
  typedef struct packed {
    ddr_cmd_e    cmd;
    logic [1:0]  bank;
    logic [12:0] addr;    // row, column or precharge address
  } dram_cmd_t;

endpackage

`default_nettype wire

/* hw/cmd_timing.sv */
`default_nettype none
`include "ddr_ctrl_defines.svh"

module cmd_timing
(
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire ddr_ctrl_pkg::ddr_cmd_e cmd_next,
  input  wire logic                   change_req,
  output logic                        change_ok,
  output logic                        page_open,
  output logic                        prch_pending
);

  import ddr_ctrl_pkg::*;

  ddr_cmd_e   state;        // last command taken
  logic [3:0] counter;      // spacing count, runs up to done
  logic       state_col;    // state is a column command
  logic       next_col;
  logic       repeat_ok;
  logic       take;

  assign next_col = (cmd_next == READ) || (cmd_next == WRTE);

  // same column op again on the open page, only the ACTV reload point
  // has to be passed before it may go
  assign repeat_ok = state_col && (cmd_next == state) && (counter > `DDR_CNT_ACTV);

  assign change_ok = (counter == `DDR_CNT_DONE) || repeat_ok;
  assign take      = change_req && change_ok;

  always_ff @(posedge CLK)
    if (!RST)
    begin
      state        <= PRCH;
      counter      <= `DDR_CNT_DONE;
      state_col    <= 1'b0;
      page_open    <= 1'b0;
      prch_pending <= 1'b0;
    end
    else if (take)
    begin
      state        <= cmd_next;
      state_col    <= next_col;
      prch_pending <= (cmd_next == PRCH);   // sequencer puts it on the bus next
      if (cmd_next == ACTV)
        page_open <= 1'b1;
      else if (cmd_next == PRCH)
        page_open <= 1'b0;
      case (cmd_next)
        ACTV:    counter <= `DDR_CNT_ACTV;
        ARSR:    counter <= `DDR_CNT_ARSR;
        default: counter <= `DDR_CNT_DEFAULT;
      endcase
    end
    else
    begin
      prch_pending <= 1'b0;
      if (counter != `DDR_CNT_DONE)
        counter <= counter + 4'd1;   // holds at done while idle
    end

  // the sequencer must close the page before it opens another row
  a_actv_closed: assert property (@(posedge CLK) disable iff (!RST)
    (take && (cmd_next == ACTV)) |-> !page_open)
    else $error("ACTV taken while a page is open");

endmodule

`default_nettype wire

/* hw/cmd_sequencer.sv */
`default_nettype none
`include "ddr_ctrl_defines.svh"

module cmd_sequencer
(
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   req_valid,
  input  wire ddr_ctrl_pkg::mem_req_t req,
  output logic                        req_ready,
  input  wire logic                   refresh_toggle,
  input  wire logic                   change_ok,
  input  wire logic                   page_open,
  input  wire logic                   prch_pending,
  output ddr_ctrl_pkg::ddr_cmd_e      cmd_next,
  output logic                        change_req,
  output ddr_ctrl_pkg::dram_cmd_t     dram_cmd,
  output logic                        col_issue,
  output logic                        col_we,
  output logic [31:0]                 wdata_hold
);

  import ddr_ctrl_pkg::*;

  localparam int ROW_W  = `DDR_ROW_MSB - `DDR_ROW_LSB + 1;
  localparam int BANK_W = `DDR_BANK_MSB - `DDR_BANK_LSB + 1;

  ddr_cmd_e                cmd_q [0:2];   // head at index 0
  logic [2:0]              row_q;         // entry takes the row address
  logic [1:0]              cmd_cnt;       // commands left
  mem_req_t                req_q;
  logic [ROW_W+BANK_W-1:0] page_tag;      // row and bank of the open page
  logic                    refresh_ack;
  logic                    refresh_due;
  logic                    accept;
  logic                    take;
  logic                    page_hit;
  ddr_cmd_e                col_cmd;
  logic [ROW_W-1:0]        row_f;
  logic [BANK_W-1:0]       bank_f;
  logic [`DDR_COL_MSB:0]   col_f;

  assign row_f  = req_q.addr[`DDR_ROW_MSB:`DDR_ROW_LSB];
  assign bank_f = req_q.addr[`DDR_BANK_MSB:`DDR_BANK_LSB];
  assign col_f  = req_q.addr[`DDR_COL_MSB:0];

  assign refresh_due = refresh_ack ^ refresh_toggle;   // any edge on the toggle
  assign change_req  = (cmd_cnt != 2'd0);
  assign cmd_next    = cmd_q[0];
  assign req_ready   = !change_req && !refresh_due;
  assign accept      = req_valid && req_ready;
  assign take        = change_req && change_ok;

  assign col_cmd  = req.we ? WRTE : READ;
  assign page_hit = page_open &&
                    ({req.addr[`DDR_ROW_MSB:`DDR_ROW_LSB],
                      req.addr[`DDR_BANK_MSB:`DDR_BANK_LSB]} == page_tag);

  assign col_issue  = take && ((cmd_q[0] == READ) || (cmd_q[0] == WRTE));
  assign col_we     = req_q.we;
  assign wdata_hold = req_q.wdata;

  always_ff @(posedge CLK)
    if (!RST)
    begin
      refresh_ack <= refresh_toggle;
      cmd_cnt     <= 2'd0;
      row_q       <= 3'b000;
      cmd_q[0]    <= NOOP;
      cmd_q[1]    <= NOOP;
      cmd_q[2]    <= NOOP;
    end
    else if (take)
    begin
      cmd_q[0] <= cmd_q[1];   // pop the head
      cmd_q[1] <= cmd_q[2];
      cmd_q[2] <= NOOP;
      row_q    <= {1'b0, row_q[2:1]};
      cmd_cnt  <= cmd_cnt - 2'd1;
    end
    else if (!change_req && refresh_due)
    begin
      // refresh wins over a waiting request
      refresh_ack <= refresh_toggle;
      cmd_q[0]    <= PRCH;
      cmd_q[1]    <= ARSR;
      cmd_q[2]    <= NOOP;
      row_q       <= 3'b000;
      cmd_cnt     <= 2'd2;
    end
    else if (accept)
    begin
      if (page_hit)
      begin
        cmd_q[0] <= col_cmd;
        row_q    <= 3'b000;
        cmd_cnt  <= 2'd1;
      end
      else
      begin
        cmd_q[0] <= PRCH;
        cmd_q[1] <= ACTV;
        cmd_q[2] <= col_cmd;
        row_q    <= 3'b010;   // ACTV carries the row
        cmd_cnt  <= 2'd3;
      end
    end

  always_ff @(posedge CLK)
  begin
    if (accept)
      req_q <= req;
    if (take && row_q[0])
      page_tag <= {row_f, bank_f};
  end

  always_ff @(posedge CLK)
    if (!RST)
      dram_cmd <= '{cmd: NOOP, bank: '0, addr: '0};
    else if (prch_pending)
      dram_cmd <= '{cmd: PRCH, bank: dram_cmd.bank, addr: `DDR_PRCH_ADDR};
    else if (take && (cmd_q[0] != PRCH))
    begin
      dram_cmd.cmd  <= cmd_q[0];
      dram_cmd.bank <= bank_f;
      dram_cmd.addr <= row_q[0] ? {row_f[11:10], 1'b0, row_f[9:0]} : col_f;   // A10 kept low
    end
    else
      dram_cmd.cmd <= NOOP;

  // a column command only ever goes to an open page
  a_col_open: assert property (@(posedge CLK) disable iff (!RST)
    col_issue |-> page_open)
    else $error("column command issued with no open page");

endmodule

`default_nettype wire

/* hw/data_path.sv */
`default_nettype none
`include "ddr_ctrl_defines.svh"

module data_path
(
  input  wire logic        CLK,
  input  wire logic        RST,
  input  wire logic        col_issue,
  input  wire logic        col_we,
  input  wire logic [31:0] wdata_hold,
  input  wire logic [15:0] dq_in,
  output logic [15:0]      dq_out,
  output logic             dq_oe,
  output logic             dm,
  output logic             rsp_valid,
  output logic [31:0]      rsp_data
);

  logic [2:0]              wr_sh;     // bit n set n+1 cycles after a write issue
  logic [`DDR_CAS_LAT+1:0] rd_sh;     // bit n set n cycles after READ on the bus
  logic [31:0]             wdata_q;
  logic                    wr_issue;
  logic                    rd_issue;
  logic                    wr_beat;

  assign wr_issue = col_issue && col_we;
  assign rd_issue = col_issue && !col_we;
  assign wr_beat  = wr_sh[1] || wr_sh[2];

  always_ff @(posedge CLK)
    if (!RST)
    begin
      wr_sh     <= '0;
      rd_sh     <= '0;
      dq_oe     <= 1'b0;
      dm        <= 1'b1;   // masked while idle
      rsp_valid <= 1'b0;
    end
    else
    begin
      wr_sh     <= {wr_sh[1:0], wr_issue};
      rd_sh     <= {rd_sh[`DDR_CAS_LAT:0], rd_issue};
      dq_oe     <= wr_beat;
      dm        <= !wr_beat;
      rsp_valid <= rd_sh[`DDR_CAS_LAT+1];   // after the high beat
    end

  always_ff @(posedge CLK)
  begin
    if (wr_issue)
      wdata_q <= wdata_hold;
    if (wr_sh[1])
      dq_out <= wdata_q[15:0];    // low half first
    else if (wr_sh[2])
      dq_out <= wdata_q[31:16];
    if (rd_sh[`DDR_CAS_LAT])
      rsp_data[15:0] <= dq_in;
    if (rd_sh[`DDR_CAS_LAT+1])
      rsp_data[31:16] <= dq_in;
  end

  // command spacing upstream keeps write bursts apart
  a_oe_burst: assert property (@(posedge CLK) disable iff (!RST)
    (dq_oe && $past(dq_oe)) |=> !dq_oe)
    else $error("dq_oe high for more than two cycles");

endmodule

`default_nettype wire

/* hw/ddr_ctrl_top.sv */
`default_nettype none

module ddr_ctrl_top
(
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   req_valid,
  output logic                        req_ready,
  input  wire ddr_ctrl_pkg::mem_req_t req,
  output logic                        rsp_valid,
  output logic [31:0]                 rsp_data,
  input  wire logic                   refresh_toggle,
  output ddr_ctrl_pkg::dram_cmd_t     dram_cmd,
  output logic [15:0]                 dq_out,
  output logic                        dq_oe,
  output logic                        dm,
  input  wire logic [15:0]            dq_in
);

  import ddr_ctrl_pkg::*;

  ddr_cmd_e    cmd_next;
  logic        change_req;
  logic        change_ok;
  logic        page_open;
  logic        prch_pending;
  logic        col_issue;
  logic        col_we;
  logic [31:0] wdata_hold;

  cmd_timing u_timing (
    .CLK(CLK), .RST(RST), .cmd_next(cmd_next), .change_req(change_req),
    .change_ok(change_ok), .page_open(page_open), .prch_pending(prch_pending));

  cmd_sequencer u_seq (
    .CLK(CLK), .RST(RST), .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .refresh_toggle(refresh_toggle), .change_ok(change_ok), .page_open(page_open),
    .prch_pending(prch_pending), .cmd_next(cmd_next), .change_req(change_req),
    .dram_cmd(dram_cmd), .col_issue(col_issue), .col_we(col_we),
    .wdata_hold(wdata_hold));

  data_path u_data (
    .CLK(CLK), .RST(RST), .col_issue(col_issue), .col_we(col_we),
    .wdata_hold(wdata_hold), .dq_in(dq_in), .dq_out(dq_out), .dq_oe(dq_oe),
    .dm(dm), .rsp_valid(rsp_valid), .rsp_data(rsp_data));

endmodule

`default_nettype wire

/* tests/tb_ddr_tests.svh */
`ifndef TB_DDR_TESTS_SVH
`define TB_DDR_TESTS_SVH

  logic [11:0] row_a;      // page written first and reused later
  logic [1:0]  bank_a;
  logic [12:0] col_a;
  logic [31:0] data_a;
  int          log_base;   // first bus_log entry of the running test

  function automatic logic [12:0] act_addr(input logic [11:0] row);
    return {row[11:10], 1'b0, row[9:0]};
  endfunction

  // addr or bank below zero is not compared
  task automatic check_cmd(input int idx, input ddr_cmd_e cmd, input int addr, input int bank);
    check(32'(bus_log[log_base + idx].cmd), 32'(cmd), "bus command");
    if (addr >= 0)
      check(32'(bus_log[log_base + idx].addr), addr, "bus address");
    if (bank >= 0)
      check(32'(bus_log[log_base + idx].bank), bank, "bus bank");
  endtask

  task automatic test_reset();
    check(32'(req_ready), 32'd1, "req_ready after reset");
    check(32'(dram_cmd.cmd), 32'(NOOP), "bus after reset");
    check(32'(dq_oe), 32'd0, "dq_oe after reset");
    check(32'(dm), 32'd1, "dm after reset");
    check(32'(rsp_valid), 32'd0, "rsp_valid after reset");
  endtask

  task automatic test_write_closed();
    logic [31:0] r;
    int          base;
    r = rand_bits(27);
    row_a = r[26:15];
    bank_a = r[14:13];
    col_a = r[12:0];
    data_a = rand_bits(32);
    base = wr_count;
    log_base = bus_log.size();
    send_req({row_a, bank_a, col_a}, 1'b1, data_a);
    wait_writes(base + 1);
    check(32'(bus_log.size() - log_base), 32'd3, "commands for a closed page write");
    check_cmd(0, PRCH, int'(`DDR_PRCH_ADDR), -1);
    check_cmd(1, ACTV, int'(act_addr(row_a)), int'(bank_a));
    check_cmd(2, WRTE, int'(col_a), int'(bank_a));
    check(32'(bus_time[log_base + 1] - bus_time[log_base] >= 4), 32'd1, "PRCH to ACTV gap");
    check(32'(bus_time[log_base + 2] - bus_time[log_base + 1] >= 3), 32'd1, "ACTV to WRTE gap");
    check(last_wr, data_a, "write beats on dq_out");
  endtask

  task automatic test_read_open();
    logic [31:0] data;
    log_base = bus_log.size();
    send_req({row_a, bank_a, col_a}, 1'b0, 32'h0);
    wait_rsp(data);
    check(data, data_a, "read data from the open page");
    check(32'(bus_log.size() - log_base), 32'd1, "commands for a page hit");
    check_cmd(0, READ, int'(col_a), int'(bank_a));
  endtask

  task automatic test_page_miss();
    logic [31:0] r;
    logic [31:0] data;
    logic [11:0] row_b;
    r = rand_bits(25);
    row_b = (r[24:13] == row_a) ? ~row_a : r[24:13];
    log_base = bus_log.size();
    send_req({row_b, bank_a, r[12:0]}, 1'b0, 32'h0);
    wait_rsp(data);
    check(data, fill_word({row_b, bank_a, r[12:0]}), "read data after a page miss");
    check(32'(bus_log.size() - log_base), 32'd3, "commands for a page miss");
    check_cmd(0, PRCH, int'(`DDR_PRCH_ADDR), -1);
    check_cmd(1, ACTV, int'(act_addr(row_b)), int'(bank_a));
    check_cmd(2, READ, int'(r[12:0]), int'(bank_a));
  endtask

  task automatic test_refresh();
    logic [31:0] data;
    int          n;
    log_base = bus_log.size();
    refresh_toggle = !refresh_toggle;
    @(negedge CLK);
    for (n = 0; dram_cmd.cmd != ARSR; n++)
    begin
      if (n == 200)
        stop_run("timeout waiting for the refresh command");
      check(32'(req_ready), 32'd0, "req_ready while refresh runs");
      @(negedge CLK);
    end
    @(negedge CLK);
    check(32'(bus_log.size() - log_base), 32'd2, "commands for a refresh");
    check_cmd(0, PRCH, int'(`DDR_PRCH_ADDR), -1);
    check_cmd(1, ARSR, -1, -1);
    log_base = bus_log.size();   // refresh closed the page
    send_req({row_a, bank_a, col_a}, 1'b0, 32'h0);
    wait_rsp(data);
    check(data, data_a, "read data after refresh");
    check(32'(bus_log.size() - log_base), 32'd3, "commands after refresh");
    check_cmd(1, ACTV, int'(act_addr(row_a)), int'(bank_a));
  endtask

  task automatic test_backpressure();
    logic [12:0] cols [4];
    logic [31:0] words [4];
    logic [31:0] r;
    int          base;
    int          i;
    base = wr_count;
    log_base = bus_log.size();
    r = rand_bits(11);
    for (i = 0; i < 4; i++)
    begin
      cols[i] = {r[10:0], 2'(i)};
      words[i] = rand_bits(32);
    end
    req_valid = 1'b1;   // held across all four requests
    for (i = 0; i < 4; i++)
    begin
      req.addr = {row_a, bank_a, cols[i]};
      req.we = 1'b1;
      req.wdata = words[i];
      wait_ready();
      @(negedge CLK);
    end
    req_valid = 1'b0;
    wait_writes(base + 4);
    check(32'(bus_log.size() - log_base), 32'd4, "column commands under back-pressure");
    for (i = 0; i < 4; i++)
    begin
      check_cmd(i, WRTE, int'(cols[i]), int'(bank_a));
      check(mem[{row_a, bank_a, cols[i]}], words[i], "word stored under back-pressure");
    end
  endtask

`endif

/* tests/tb_ddr_ctrl.sv */
`default_nettype none
`include "ddr_ctrl_defines.svh"

module tb_ddr_ctrl;

  import ddr_ctrl_pkg::*;

  logic        CLK = 1'b0;
  logic        RST;
  logic        req_valid;
  logic        req_ready;
  mem_req_t    req;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        refresh_toggle;
  dram_cmd_t   dram_cmd;
  logic [15:0] dq_out;
  logic        dq_oe;
  logic        dm;
  logic [15:0] dq_in = 16'h0000;

  logic [31:0] lfsr_state = 32'h6242;
  int          cycle = 0;
  int          wr_count = 0;        // write bursts seen by the model
  logic [31:0] last_wr;
  logic [11:0] open_row;
  logic [15:0] wr_low;
  dram_cmd_t   bus_log [$];         // every non-NOOP bus word
  int          bus_time [$];
  logic [31:0] mem [logic [26:0]];
  logic [26:0] wr_key [int];        // WRTE address by the cycle it was seen
  logic [15:0] rd_beat [int];       // dq_in value by cycle

  ddr_ctrl_top u_dut (.*);

  always #2 CLK = !CLK;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    repeat (n)
    begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // contents of a location that was never written
  function automatic logic [31:0] fill_word(input logic [26:0] a);
    return {a[15:0], a[26:11]} ^ 32'h3c5a_96e1;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      stop_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic wait_ready();
    int n;
    for (n = 0; !req_ready; n++)
    begin
      if (n == 200)
        stop_run("timeout waiting for req_ready");
      @(negedge CLK);
    end
  endtask

  task automatic wait_writes(input int target);
    int n;
    for (n = 0; wr_count < target; n++)
    begin
      if (n == 200)
        stop_run("timeout waiting for write beats");
      @(negedge CLK);
    end
  endtask

  task automatic wait_rsp(output logic [31:0] data);
    int n;
    for (n = 0; !rsp_valid; n++)
    begin
      if (n == 200)
        stop_run("timeout waiting for rsp_valid");
      @(negedge CLK);
    end
    data = rsp_data;
  endtask

  task automatic send_req(input logic [26:0] addr, input logic we, input logic [31:0] wdata);
    @(negedge CLK);
    req_valid = 1'b1;
    req.addr = addr;
    req.we = we;
    req.wdata = wdata;
    wait_ready();
    @(negedge CLK);   // taken on the rising edge just passed
    req_valid = 1'b0;
  endtask

  // SDRAM model, bus and write data are stable at the falling edge
  always @(negedge CLK)
  begin
    logic [26:0] key;
    logic [31:0] word;
    cycle = cycle + 1;
    dq_in = rd_beat.exists(cycle) ? rd_beat[cycle] : 16'h0000;
    if (wr_key.exists(cycle - 2) || wr_key.exists(cycle - 3))
      if (!dq_oe || dm)
        stop_run("write beat without dq_oe or with dm set");
    if (wr_key.exists(cycle - 2))
      wr_low = dq_out;   // low half first
    if (wr_key.exists(cycle - 3))
    begin
      last_wr = {dq_out, wr_low};
      mem[wr_key[cycle - 3]] = last_wr;
      wr_count = wr_count + 1;
    end
    key = {open_row, dram_cmd.bank, dram_cmd.addr};
    if (dram_cmd.cmd != NOOP)
    begin
      bus_log.push_back(dram_cmd);
      bus_time.push_back(cycle);
    end
    if (dram_cmd.cmd == ACTV)
      open_row = {dram_cmd.addr[12:11], dram_cmd.addr[9:0]};   // A10 not part of the row
    else if (dram_cmd.cmd == WRTE)
      wr_key[cycle] = key;
    else if (dram_cmd.cmd == READ)
    begin
      word = mem.exists(key) ? mem[key] : fill_word(key);
      rd_beat[cycle + `DDR_CAS_LAT] = word[15:0];
      rd_beat[cycle + `DDR_CAS_LAT + 1] = word[31:16];
    end
  end

  `include "tb_ddr_tests.svh"

  initial
  begin
    RST = 1'b0;
    req_valid = 1'b0;
    req = '0;
    refresh_toggle = 1'b0;
    repeat (16) @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    test_reset();
    test_write_closed();
    test_read_open();
    test_page_miss();
    test_refresh();
    test_backpressure();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* ddr_ctrl.f */
+incdir+hw
+incdir+tests
hw/ddr_ctrl_pkg.sv
hw/cmd_timing.sv
hw/cmd_sequencer.sv
hw/data_path.sv
hw/ddr_ctrl_top.sv
tests/tb_ddr_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ddr_ctrl -f ddr_ctrl.f -o tb_ddr_ctrl \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_ddr_ctrl > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: simulation ended early"; exit 1; }
echo "PASS"
